// ==== hw/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W      = 16;
	localparam int SHAMT_W    = $clog2(XLEN);

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		R_TYPE = 6'b000000,
		J      = 6'b000010,
		BEQ    = 6'b000100,
		BNE    = 6'b000101,
		ADDI   = 6'b001000,
		ADDIU  = 6'b001001,
		SLTI   = 6'b001010,
		SLTIU  = 6'b001011,
		ANDI   = 6'b001100,
		ORI    = 6'b001101,
		LW     = 6'b100011,
		// Nonstandard store encoding of this ISA variant
		SW     = 6'b100101
	} opcode_e;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000,
		ALU_SUB = 4'b0001,
		ALU_AND = 4'b0010,
		ALU_OR  = 4'b0011,
		ALU_SLL = 4'b0100,
		ALU_SRL = 4'b0101,
		ALU_SLT = 4'b1000
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU = 2'b00,
		WB_MEM = 2'b01
	} wb_sel_e;

	// All zero means no side effect anywhere down the pipe
	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    mem_rd;
		logic    mem_wr;
		logic    reg_wr;
		wb_sel_e wb_sel;
	} ctrl_t;

	typedef struct packed {
		ctrl_t                ctrl;
		word_t                rs_val;
		word_t                rt_val;
		word_t                imm_ext;
		logic [SHAMT_W-1:0]   shamt;
		reg_addr_t            dest;
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

endpackage

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file import mips_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t rs_addr,
	input  reg_addr_t rt_addr,
	input  wb_t       wb,
	output word_t     rs_val,
	output word_t     rt_val
);

	localparam int NUM_REGS = 2**REG_ADDR_W;

	word_t regs [NUM_REGS];

	// Write lands at the end of the write-back cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// No bypass so a same-cycle read sees the old value
	assign rs_val = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_val = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import mips_pkg::*; #(
	parameter int IMEM_DEPTH = 64
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  imem_load_en,
	input  word_t imem_load_addr,
	input  word_t imem_load_data,
	input  logic  redirect,
	input  word_t target,
	output word_t instr_d,
	output word_t pc_inc_d
);

	localparam int IMEM_AW = $clog2(IMEM_DEPTH);

	word_t imem [IMEM_DEPTH];
	word_t pc;
	word_t pc_inc;
	word_t next_pc;
	word_t instr;

	// Load port writes by word index, also during reset
	always_ff @(posedge clk) begin
		if (imem_load_en) begin
			imem[imem_load_addr[IMEM_AW-1:0]] <= imem_load_data;
		end
	end

	assign instr   = imem[pc[IMEM_AW+1:2]];
	assign pc_inc  = pc + word_t'(4);
	// Redirect comes from decode, so the next sequential word is the delay slot
	assign next_pc = redirect ? target : pc_inc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= next_pc;
		end
	end

	// Fetch/decode register clears to a NOP
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instr_d <= '0;
		end else begin
			instr_d  <= instr;
			pc_inc_d <= pc_inc;
		end
	end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage import mips_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  word_t     instr_d,
	input  word_t     pc_inc_d,
	input  word_t     rs_val,
	input  word_t     rt_val,
	output reg_addr_t rs_addr,
	output reg_addr_t rt_addr,
	output logic      redirect,
	output word_t     target,
	output id_ex_t    id_ex
);

	opcode_e          opcode;
	funct_e           funct;
	reg_addr_t        rd_addr;
	logic [IMM_W-1:0] imm;
	logic [25:0]      jump_index;
	word_t            imm_ext;
	word_t            branch_target;
	word_t            jump_target;
	ctrl_t            ctrl;
	logic             dest_rd;
	logic             operands_equal;
	logic             take_branch;
	logic             take_jump;
	id_ex_t           id_ex_next;

	// Instruction fields
	assign opcode     = opcode_e'(instr_d[31:26]);
	assign funct      = funct_e'(instr_d[5:0]);
	assign rs_addr    = instr_d[25:21];
	assign rt_addr    = instr_d[20:16];
	assign rd_addr    = instr_d[15:11];
	assign imm        = instr_d[IMM_W-1:0];
	assign jump_index = instr_d[25:0];

	// Immediates are always zero-extended
	assign imm_ext = {{(XLEN-IMM_W){1'b0}}, imm};

	assign operands_equal = (rs_val == rt_val);
	assign branch_target  = pc_inc_d + {imm_ext[XLEN-3:0], 2'b00};
	assign jump_target    = {pc_inc_d[XLEN-1:XLEN-4], jump_index, 2'b00};

	always_comb begin
		ctrl        = '0;
		dest_rd     = 1'b0;
		take_branch = 1'b0;
		take_jump   = 1'b0;
		case (opcode)
			R_TYPE: begin
				dest_rd     = 1'b1;
				ctrl.reg_wr = 1'b1;
				case (funct)
					FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:          ctrl.alu_op = ALU_AND;
					FN_OR:           ctrl.alu_op = ALU_OR;
					FN_SLL:          ctrl.alu_op = ALU_SLL;
					FN_SRL:          ctrl.alu_op = ALU_SRL;
					FN_SLT, FN_SLTU: ctrl.alu_op = ALU_SLT;
					default:         ctrl.reg_wr = 1'b0;
				endcase
			end
			ADDI, ADDIU, ANDI, ORI, SLTI, SLTIU: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_wr      = 1'b1;
				case (opcode)
					ANDI:        ctrl.alu_op = ALU_AND;
					ORI:         ctrl.alu_op = ALU_OR;
					SLTI, SLTIU: ctrl.alu_op = ALU_SLT;
					default:     ctrl.alu_op = ALU_ADD;
				endcase
			end
			LW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_rd      = 1'b1;
				ctrl.reg_wr      = 1'b1;
				ctrl.wb_sel      = WB_MEM;
			end
			SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_wr      = 1'b1;
			end
			BEQ: take_branch = operands_equal;
			BNE: take_branch = !operands_equal;
			J:   take_jump   = 1'b1;
			// Unknown opcodes fall through as a NOP
			default: ctrl = '0;
		endcase
	end

	assign redirect = take_branch || take_jump;
	assign target   = take_jump ? jump_target : branch_target;

	always_comb begin
		id_ex_next.ctrl    = ctrl;
		id_ex_next.rs_val  = rs_val;
		id_ex_next.rt_val  = rt_val;
		id_ex_next.imm_ext = imm_ext;
		id_ex_next.shamt   = instr_d[10:6];
		id_ex_next.dest    = dest_rd ? rd_addr : rt_addr;
	end

	// Decode/execute register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.ctrl <= '0;
		end else begin
			id_ex <= id_ex_next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage import mips_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  id_ex_t  id_ex,
	output ex_mem_t ex_mem
);

	word_t op_a;
	word_t op_b;
	word_t alu_result;

	assign op_a = id_ex.rs_val;
	assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm_ext : id_ex.rt_val;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_ADD: alu_result = op_a + op_b;
			ALU_SUB: alu_result = op_a - op_b;
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			// Shifts act on rt by the instruction's shamt
			ALU_SLL: alu_result = op_b << id_ex.shamt;
			ALU_SRL: alu_result = op_b >> id_ex.shamt;
			// Unsigned compare for both SLT and SLTU
			ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
			default: alu_result = '0;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.ctrl <= '0;
		end else begin
			ex_mem.ctrl       <= id_ex.ctrl;
			ex_mem.alu_result <= alu_result;
			ex_mem.store_data <= id_ex.rt_val;
			ex_mem.dest       <= id_ex.dest;
		end
	end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_stage import mips_pkg::*; #(
	parameter int DMEM_DEPTH = 16
) (
	input  logic    clk,
	input  logic    rst_n,
	input  ex_mem_t ex_mem,
	output wb_t     wb
);

	localparam int DMEM_AW = $clog2(DMEM_DEPTH);

	word_t              dmem [DMEM_DEPTH];
	logic [DMEM_AW-1:0] dmem_idx;
	word_t              load_data;

	// Byte address to word index
	assign dmem_idx = ex_mem.alu_result[DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (ex_mem.ctrl.mem_wr) begin
			dmem[dmem_idx] <= ex_mem.store_data;
		end
	end

	assign load_data = ex_mem.ctrl.mem_rd ? dmem[dmem_idx] : '0;

	// Memory/write-back register; r0 never gets a strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.en <= 1'b0;
		end else begin
			wb.en   <= ex_mem.ctrl.reg_wr && (ex_mem.dest != '0);
			wb.addr <= ex_mem.dest;
			wb.data <= (ex_mem.ctrl.wb_sel == WB_MEM) ? load_data : ex_mem.alu_result;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mips_pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_pipeline import mips_pkg::*; #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 16
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  imem_load_en,
	input  word_t imem_load_addr,
	input  word_t imem_load_data,
	output wb_t   wb
);

	word_t     instr_d;
	word_t     pc_inc_d;
	logic      redirect;
	word_t     target;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t     rs_val;
	word_t     rt_val;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;

	fetch_stage #(
		.IMEM_DEPTH(IMEM_DEPTH)
	) i_fetch_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.imem_load_en  (imem_load_en),
		.imem_load_addr(imem_load_addr),
		.imem_load_data(imem_load_data),
		.redirect      (redirect),
		.target        (target),
		.instr_d       (instr_d),
		.pc_inc_d      (pc_inc_d)
	);

	decode_stage i_decode_stage (
		.clk     (clk),
		.rst_n   (rst_n),
		.instr_d (instr_d),
		.pc_inc_d(pc_inc_d),
		.rs_val  (rs_val),
		.rt_val  (rt_val),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.redirect(redirect),
		.target  (target),
		.id_ex   (id_ex)
	);

	// Written from the write-back port, read by decode
	register_file i_register_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.wb     (wb),
		.rs_val (rs_val),
		.rt_val (rt_val)
	);

	execute_stage i_execute_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.id_ex (id_ex),
		.ex_mem(ex_mem)
	);

	memory_stage #(
		.DMEM_DEPTH(DMEM_DEPTH)
	) i_memory_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.ex_mem(ex_mem),
		.wb    (wb)
	);

endmodule

`default_nettype wire

// ==== tests/mips_pipeline_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_pipeline_assertions import mips_pkg::*; (
	input logic clk,
	input logic rst_n,
	input wb_t  wb
);

	// Count of failed assertions
	int unsigned failures = 0;

	// Reset is sampled at the edge, so the strobe drops from the next cycle on
	no_wb_in_reset: assert property (@(posedge clk) !rst_n |=> !wb.en)
	else begin
		failures++;
		$error("wb.en high one cycle after rst_n was sampled low");
	end

	no_wb_to_r0: assert property (@(posedge clk) disable iff (!rst_n) wb.en |-> (wb.addr != '0))
	else begin
		failures++;
		$error("wb.en high for register 0");
	end

	wb_data_known: assert property (@(posedge clk) disable iff (!rst_n)
		wb.en |-> !$isunknown(wb.data))
	else begin
		failures++;
		$error("wb.data has unknown bits while wb.en is high");
	end

endmodule

`default_nettype wire

// ==== tests/mips_pipeline_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_pipeline_tb import mips_pkg::*; ();

	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 16;
	localparam int RUN_CYCLES = 32;
	// Seven program runs, initial reset, mid-program reset hold and slack
	localparam int MAX_CYCLES = 8 + 7 * (IMEM_DEPTH + RUN_CYCLES + 1) + 8 + 100;

	logic        clk;
	logic        rst_n;
	logic        imem_load_en;
	word_t       imem_load_addr;
	word_t       imem_load_data;
	wb_t         wb;
	word_t       prog[$];
	reg_addr_t   exp_addr[$];
	word_t       exp_data[$];
	reg_addr_t   got_addr[$];
	word_t       got_data[$];
	logic [31:0] lfsr_state = 32'h21f5b3cc;
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	int          assert_failures;

	mips_pipeline #(
		.IMEM_DEPTH(IMEM_DEPTH),
		.DMEM_DEPTH(DMEM_DEPTH)
	) i_mips_pipeline (
		.clk           (clk),
		.rst_n         (rst_n),
		.imem_load_en  (imem_load_en),
		.imem_load_addr(imem_load_addr),
		.imem_load_data(imem_load_data),
		.wb            (wb)
	);

	bind mips_pipeline mips_pipeline_assertions i_mips_pipeline_assertions (
		.clk  (clk),
		.rst_n(rst_n),
		.wb   (wb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the tests did not complete", MAX_CYCLES);
		$display("Test failed");
		$finish;
	end

	// Write-back monitor sampled mid-cycle
	always @(negedge clk) begin
		if (wb.en) begin
			got_addr.push_back(wb.addr);
			got_data.push_back(wb.data);
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic word_t rtype(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
			logic [4:0] sh);
		return {R_TYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t itype(opcode_e op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_instr(logic [25:0] index);
		return {J, index};
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic new_program();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic add_instr(word_t instr);
		prog.push_back(instr);
	endtask

	// Instruction whose write-back must appear on the port
	task automatic expect_instr(word_t instr, reg_addr_t rd, word_t value);
		prog.push_back(instr);
		exp_addr.push_back(rd);
		exp_data.push_back(value);
	endtask

	task automatic pad_nops(int n);
		repeat (n) prog.push_back(32'h0);
	endtask

	// Load under reset, zero the rest, then let the pipeline run
	task automatic run_program(int run_cycles);
		rst_n = 1'b0;
		got_addr.delete();
		got_data.delete();
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			imem_load_en   = 1'b1;
			imem_load_addr = word_t'(i);
			imem_load_data = (i < prog.size()) ? prog[i] : 32'h0;
			next_cycle();
		end
		imem_load_en = 1'b0;
		rst_n        = 1'b1;
		repeat (run_cycles) next_cycle();
	endtask

	task automatic check_writebacks(string name);
		int n;
		n = (exp_addr.size() > got_addr.size()) ? exp_addr.size() : got_addr.size();
		for (int i = 0; i < n; i++) begin
			check_count++;
			if (i >= got_addr.size()) begin
				$display("%s: write-back %0d to r%0d never happened", name, i, exp_addr[i]);
				error_count++;
			end else if (i >= exp_addr.size()) begin
				$display("%s: unexpected extra write-back %0d to r%0d", name, i, got_addr[i]);
				error_count++;
			end else begin
				if (got_addr[i] !== exp_addr[i]) begin
					$display("CHECK FAILED %s wb.addr #%0d got 0x%0h expected 0x%0h",
						name, i, got_addr[i], exp_addr[i]);
					error_count++;
				end
				if (got_data[i] !== exp_data[i]) begin
					$display("CHECK FAILED %s wb.data #%0d got 0x%0h expected 0x%0h",
						name, i, got_data[i], exp_data[i]);
					error_count++;
				end
			end
		end
	endtask

	task automatic alu_ops();
		word_t a;
		word_t b;
		a = random_bits(16);
		b = random_bits(16);
		new_program();
		expect_instr(itype(ORI, 5'd1, 5'd0, a[15:0]), 5'd1, a);
		expect_instr(itype(ORI, 5'd2, 5'd0, b[15:0]), 5'd2, b);
		pad_nops(3);
		expect_instr(rtype(FN_ADD, 5'd3, 5'd1, 5'd2, 5'd0), 5'd3, a + b);
		expect_instr(rtype(FN_SUB, 5'd4, 5'd1, 5'd2, 5'd0), 5'd4, a - b);
		expect_instr(rtype(FN_AND, 5'd5, 5'd1, 5'd2, 5'd0), 5'd5, a & b);
		expect_instr(rtype(FN_OR, 5'd6, 5'd1, 5'd2, 5'd0), 5'd6, a | b);
		// Both compare forms are unsigned
		expect_instr(rtype(FN_SLT, 5'd7, 5'd1, 5'd2, 5'd0), 5'd7, word_t'(a < b));
		expect_instr(rtype(FN_SLTU, 5'd8, 5'd2, 5'd1, 5'd0), 5'd8, word_t'(b < a));
		run_program(RUN_CYCLES);
		check_writebacks("alu");
	endtask

	task automatic shift_ops();
		word_t      v;
		logic [4:0] s1;
		logic [4:0] s2;
		logic [4:0] s3;
		v  = random_bits(16);
		s1 = 5'(random_bits(5));
		s2 = 5'(random_bits(5));
		s3 = 5'(random_bits(5));
		new_program();
		expect_instr(itype(ORI, 5'd1, 5'd0, v[15:0]), 5'd1, v);
		pad_nops(3);
		expect_instr(rtype(FN_SLL, 5'd2, 5'd0, 5'd1, s1), 5'd2, v << s1);
		expect_instr(rtype(FN_SRL, 5'd3, 5'd0, 5'd1, s2), 5'd3, v >> s2);
		pad_nops(2);
		// Right shift of the left-shifted word reaches the upper bits
		expect_instr(rtype(FN_SRL, 5'd4, 5'd0, 5'd2, s3), 5'd4, (v << s1) >> s3);
		run_program(RUN_CYCLES);
		check_writebacks("shifts");
	endtask

	task automatic immediate_ops();
		word_t a;
		word_t imm_add;
		word_t imm_and;
		word_t imm_or;
		word_t imm_slt;
		a       = random_bits(16);
		imm_add = random_bits(16) | 32'h8000;
		imm_and = random_bits(16);
		imm_or  = random_bits(16) | 32'h8000;
		imm_slt = random_bits(16) | 32'h8000;
		new_program();
		expect_instr(itype(ORI, 5'd1, 5'd0, a[15:0]), 5'd1, a);
		pad_nops(3);
		expect_instr(itype(ADDI, 5'd2, 5'd1, imm_add[15:0]), 5'd2, a + imm_add);
		expect_instr(itype(ANDI, 5'd3, 5'd1, imm_and[15:0]), 5'd3, a & imm_and);
		expect_instr(itype(ORI, 5'd4, 5'd1, imm_or[15:0]), 5'd4, a | imm_or);
		expect_instr(itype(SLTI, 5'd5, 5'd1, imm_slt[15:0]), 5'd5, word_t'(a < imm_slt));
		expect_instr(itype(ADDIU, 5'd6, 5'd0, 16'hffff), 5'd6, 32'h0000_ffff);
		run_program(RUN_CYCLES);
		check_writebacks("immediates");
	endtask

	task automatic load_store();
		word_t a;
		word_t b;
		a = random_bits(16);
		b = random_bits(16);
		new_program();
		expect_instr(itype(ORI, 5'd1, 5'd0, a[15:0]), 5'd1, a);
		expect_instr(itype(ORI, 5'd2, 5'd0, b[15:0]), 5'd2, b);
		pad_nops(3);
		add_instr(itype(SW, 5'd1, 5'd0, 16'd8));
		add_instr(itype(SW, 5'd2, 5'd0, 16'd20));
		pad_nops(1);
		expect_instr(itype(LW, 5'd3, 5'd0, 16'd8), 5'd3, a);
		expect_instr(itype(LW, 5'd4, 5'd0, 16'd20), 5'd4, b);
		run_program(RUN_CYCLES);
		check_writebacks("memory");
	endtask

	task automatic branch_and_jump();
		word_t a;
		word_t b;
		a = random_bits(16);
		b = random_bits(16);
		if (b == a) begin
			b = a ^ 32'h1;
		end
		new_program();
		expect_instr(itype(ORI, 5'd1, 5'd0, a[15:0]), 5'd1, a);
		expect_instr(itype(ORI, 5'd2, 5'd0, a[15:0]), 5'd2, a);
		expect_instr(itype(ORI, 5'd3, 5'd0, b[15:0]), 5'd3, b);
		pad_nops(3);
		// Word 6 branches to word 9
		add_instr(itype(BEQ, 5'd2, 5'd1, 16'd2));
		expect_instr(itype(ADDI, 5'd4, 5'd0, 16'd1), 5'd4, 32'd1);
		add_instr(itype(ADDI, 5'd5, 5'd0, 16'h55));
		// Word 9 falls through
		add_instr(itype(BEQ, 5'd3, 5'd1, 16'd5));
		expect_instr(itype(ADDI, 5'd6, 5'd0, 16'd2), 5'd6, 32'd2);
		expect_instr(itype(ADDI, 5'd7, 5'd0, 16'd3), 5'd7, 32'd3);
		// Word 12 branches to word 15
		add_instr(itype(BNE, 5'd3, 5'd1, 16'd2));
		expect_instr(itype(ADDI, 5'd8, 5'd0, 16'd4), 5'd8, 32'd4);
		add_instr(itype(ADDI, 5'd12, 5'd0, 16'h77));
		// Word 15 jumps to word 18
		add_instr(jump_instr(26'd18));
		expect_instr(itype(ADDI, 5'd9, 5'd0, 16'd5), 5'd9, 32'd5);
		add_instr(itype(ADDI, 5'd10, 5'd0, 16'h66));
		expect_instr(itype(ADDI, 5'd11, 5'd0, 16'd6), 5'd11, 32'd6);
		run_program(RUN_CYCLES);
		check_writebacks("control flow");
	endtask

	task automatic reset_in_flight();
		word_t a;
		word_t b;
		a = random_bits(16);
		b = random_bits(16);
		new_program();
		expect_instr(itype(ORI, 5'd1, 5'd0, a[15:0]), 5'd1, a);
		pad_nops(3);
		// Still in flight when reset hits
		add_instr(itype(ORI, 5'd2, 5'd0, b[15:0]));
		add_instr(itype(ORI, 5'd4, 5'd0, b[15:0]));
		run_program(7);
		check_writebacks("reset before");
		rst_n = 1'b0;
		for (int i = 0; i < 8; i++) begin
			next_cycle();
			if (wb.en !== 1'b0) begin
				$display("reset: write-back to r%0d while rst_n was low", wb.addr);
				error_count++;
			end
		end
		new_program();
		expect_instr(rtype(FN_ADD, 5'd3, 5'd1, 5'd0, 5'd0), 5'd3, 32'h0);
		expect_instr(rtype(FN_ADD, 5'd5, 5'd2, 5'd0, 5'd0), 5'd5, 32'h0);
		run_program(RUN_CYCLES);
		check_writebacks("reset after");
	endtask

	initial begin
		rst_n          = 1'b0;
		imem_load_en   = 1'b0;
		imem_load_addr = '0;
		imem_load_data = '0;
		repeat (8) next_cycle();
		alu_ops();
		shift_ops();
		immediate_ops();
		load_store();
		branch_and_jump();
		reset_in_flight();
		assert_failures = i_mips_pipeline.i_mips_pipeline_assertions.failures;
		$display("Write-backs checked: %0d, errors: %0d, assertion failures: %0d",
			check_count, error_count, assert_failures);
		if (error_count == 0 && assert_failures == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/mips_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_pipeline.sv
tests/mips_pipeline_assertions.sv
tests/mips_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  # Synthesizable design, package first
  - files:
      - hw/mips_pkg.sv
      - hw/register_file.sv
      - hw/fetch_stage.sv
      - hw/decode_stage.sv
      - hw/execute_stage.sv
      - hw/memory_stage.sv
      - hw/mips_pipeline.sv
  # Simulation only
  - target: test
    files:
      - tests/mips_pipeline_assertions.sv
      - tests/mips_pipeline_tb.sv
